/* design/hus_pkg.sv */
`default_nettype none

package hus_pkg;

	// fixed channel count
	localparam int HUS_CHANNELS = 8;

	typedef logic [2:0] chan_t;
	typedef logic [3:0] reg_idx_t;
	// low bit picks the byte within a memory word
	typedef logic [21:0] byte_addr_t;
	typedef logic [20:0] word_addr_t;
	typedef logic signed [7:0] sample_t;
	typedef logic [5:0] vol_t;
	// room for eight full-scale products
	typedef logic signed [17:0] dac_t;

	// per-channel register map with little-endian addresses
	localparam reg_idx_t REG_CTRL   = 4'd0;
	localparam reg_idx_t REG_START0 = 4'd1;
	localparam reg_idx_t REG_START1 = 4'd2;
	localparam reg_idx_t REG_START2 = 4'd3;
	localparam reg_idx_t REG_END0   = 4'd4;
	localparam reg_idx_t REG_END1   = 4'd5;
	localparam reg_idx_t REG_END2   = 4'd6;
	localparam reg_idx_t REG_LOOP0  = 4'd7;
	localparam reg_idx_t REG_LOOP1  = 4'd8;
	localparam reg_idx_t REG_LOOP2  = 4'd9;
	localparam reg_idx_t REG_LVOL   = 4'd10;
	localparam reg_idx_t REG_RVOL   = 4'd11;

	// control byte bits
	localparam int CTRL_ACTIVE = 7;
	localparam int CTRL_LOOP   = 6;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		FETCH,
		MIX,
		NEXT
	} seq_state_t;

endpackage

`default_nettype wire

/* design/hus_chan_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_chan_regs (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cfg_we,
	input  wire hus_pkg::chan_t      cfg_chan,
	input  wire hus_pkg::reg_idx_t   cfg_reg,
	input  wire [7:0]                cfg_wdata,
	input  wire hus_pkg::chan_t      rd_chan,
	output logic                     active,
	output logic                     loop,
	output hus_pkg::byte_addr_t      start_addr,
	output hus_pkg::byte_addr_t      end_addr,
	output hus_pkg::byte_addr_t      loop_addr,
	output hus_pkg::vol_t            lvol,
	output hus_pkg::vol_t            rvol,
	output hus_pkg::byte_addr_t      cnt,
	input  wire                      cnt_we,
	input  wire hus_pkg::byte_addr_t cnt_wdata,
	input  wire                      stop_we
);

	// only the two used control bits are kept
	logic [hus_pkg::HUS_CHANNELS-1:0] act_r;
	logic [hus_pkg::HUS_CHANNELS-1:0] loop_r;
	// address and volume bytes indexed by register number
	logic [7:0] prm [hus_pkg::HUS_CHANNELS][hus_pkg::REG_START0:hus_pkg::REG_RVOL];
	hus_pkg::byte_addr_t cnt_r [hus_pkg::HUS_CHANNELS];

	logic host_ctrl;
	logic host_go;

	// three address bytes starting at register r
	function automatic hus_pkg::byte_addr_t addr_of(hus_pkg::chan_t c, hus_pkg::reg_idx_t r);
		return {prm[c][r + 4'd2][5:0], prm[c][r + 4'd1], prm[c][r]};
	endfunction

	assign host_ctrl = cfg_we && (cfg_reg == hus_pkg::REG_CTRL);
	assign host_go = host_ctrl && cfg_wdata[hus_pkg::CTRL_ACTIVE];

	// host write comes last so it overrides a write-back to the same channel
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			act_r <= '0;
			loop_r <= '0;
		end
		else
		begin
			if (stop_we)
				act_r[rd_chan] <= 1'b0;
			if (host_ctrl)
			begin
				act_r[cfg_chan] <= cfg_wdata[hus_pkg::CTRL_ACTIVE];
				loop_r[cfg_chan] <= cfg_wdata[hus_pkg::CTRL_LOOP];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (cfg_we && cfg_reg >= hus_pkg::REG_START0 && cfg_reg <= hus_pkg::REG_RVOL)
			prm[cfg_chan][cfg_reg] <= cfg_wdata;
	end

	// activation reloads the counter from the start address
	always_ff @(posedge clk)
	begin
		if (cnt_we)
			cnt_r[rd_chan] <= cnt_wdata;
		if (host_go)
			cnt_r[cfg_chan] <= addr_of(cfg_chan, hus_pkg::REG_START0);
	end

	// read port valid one cycle after rd_chan
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			loop <= 1'b0;
		end
		else
		begin
			active <= act_r[rd_chan];
			loop <= loop_r[rd_chan];
		end
	end

	always_ff @(posedge clk)
	begin
		start_addr <= addr_of(rd_chan, hus_pkg::REG_START0);
		end_addr <= addr_of(rd_chan, hus_pkg::REG_END0);
		loop_addr <= addr_of(rd_chan, hus_pkg::REG_LOOP0);
		lvol <= prm[rd_chan][hus_pkg::REG_LVOL][5:0];
		rvol <= prm[rd_chan][hus_pkg::REG_RVOL][5:0];
		cnt <= cnt_r[rd_chan];
	end

endmodule

`default_nettype wire

/* design/hus_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_mixer (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   dac_stb,
	input  wire                   mix_en,
	input  wire hus_pkg::sample_t mix_sample,
	input  wire hus_pkg::vol_t    mix_lvol,
	input  wire hus_pkg::vol_t    mix_rvol,
	output hus_pkg::dac_t         ldac,
	output hus_pkg::dac_t         rdac
);

	hus_pkg::dac_t lacc;
	hus_pkg::dac_t racc;
	hus_pkg::dac_t smp_ext;
	hus_pkg::dac_t lprod;
	hus_pkg::dac_t rprod;

	// sample sign-extended, volumes zero-extended
	assign smp_ext = hus_pkg::dac_t'(mix_sample);
	assign lprod = smp_ext * hus_pkg::dac_t'(mix_lvol);
	assign rprod = smp_ext * hus_pkg::dac_t'(mix_rvol);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lacc <= '0;
			racc <= '0;
			ldac <= '0;
			rdac <= '0;
		end
		else if (dac_stb)
		begin
			// publish last frame, start a new one
			ldac <= lacc;
			rdac <= racc;
			lacc <= '0;
			racc <= '0;
		end
		else if (mix_en)
		begin
			lacc <= lacc + lprod;
			racc <= racc + rprod;
		end
	end

endmodule

`default_nettype wire

/* design/hus.sv */
`timescale 1ns/1ps
`default_nettype none

module hus (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      dac_stb,
	output logic                     busy,
	output hus_pkg::chan_t           rd_chan,
	input  wire                      active,
	input  wire                      loop,
	input  wire hus_pkg::byte_addr_t start_addr,
	input  wire hus_pkg::byte_addr_t end_addr,
	input  wire hus_pkg::byte_addr_t loop_addr,
	input  wire hus_pkg::vol_t       lvol,
	input  wire hus_pkg::vol_t       rvol,
	input  wire hus_pkg::byte_addr_t cnt,
	output logic                     cnt_we,
	output hus_pkg::byte_addr_t      cnt_wdata,
	output logic                     stop_we,
	output logic                     mem_req,
	output hus_pkg::word_addr_t      mem_addr,
	input  wire [15:0]               mem_data,
	input  wire                      mem_strobe,
	output logic                     mix_en,
	output hus_pkg::sample_t         mix_sample,
	output hus_pkg::vol_t            mix_lvol,
	output hus_pkg::vol_t            mix_rvol
);

	hus_pkg::seq_state_t state;
	hus_pkg::byte_addr_t cnt_next;
	logic at_end;
	logic empty;
	logic last_chan;
	logic fetch_done;

	assign cnt_next = cnt + 1'b1;
	assign at_end = (cnt_next == end_addr);
	// start equal to end means nothing to play
	assign empty = (start_addr == end_addr);
	assign last_chan = (rd_chan == hus_pkg::chan_t'(hus_pkg::HUS_CHANNELS - 1));
	assign fetch_done = (state == hus_pkg::FETCH) && mem_req && mem_strobe;

	// frame walk
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= hus_pkg::IDLE;
			busy <= 1'b0;
			mem_req <= 1'b0;
			rd_chan <= '0;
		end
		else if (dac_stb)
		begin
			// a strobe restarts the walk at channel 0 even mid-frame
			state <= hus_pkg::READ;
			busy <= 1'b1;
			mem_req <= 1'b0;
			rd_chan <= '0;
		end
		else
		begin
			case (state)
				hus_pkg::READ:
					// register file output settles
					state <= hus_pkg::FETCH;
				hus_pkg::FETCH:
				begin
					if (!active || empty)
						state <= hus_pkg::NEXT;
					else if (!mem_req)
						mem_req <= 1'b1;
					else if (mem_strobe)
					begin
						mem_req <= 1'b0;
						state <= hus_pkg::MIX;
					end
				end
				hus_pkg::MIX:
					state <= hus_pkg::NEXT;
				hus_pkg::NEXT:
				begin
					if (last_chan)
					begin
						busy <= 1'b0;
						state <= hus_pkg::IDLE;
					end
					else
					begin
						rd_chan <= rd_chan + 1'b1;
						state <= hus_pkg::READ;
					end
				end
				default:
					// idle until the next DAC strobe
					state <= hus_pkg::IDLE;
			endcase
		end
	end

	// address held from request to strobe
	always_ff @(posedge clk)
	begin
		if (state == hus_pkg::FETCH && !mem_req)
			mem_addr <= cnt[21:1];
	end

	// pick the byte and latch volumes with it
	always_ff @(posedge clk)
	begin
		if (fetch_done)
		begin
			mix_sample <= hus_pkg::sample_t'(cnt[0] ? mem_data[15:8] : mem_data[7:0]);
			mix_lvol <= lvol;
			mix_rvol <= rvol;
		end
	end

	assign mix_en = (state == hus_pkg::MIX);

	// advance, wrap to loop address, or stop at end
	always_comb
	begin
		cnt_we = 1'b0;
		stop_we = 1'b0;
		cnt_wdata = cnt_next;
		if (state == hus_pkg::MIX)
		begin
			if (!at_end)
				cnt_we = 1'b1;
			else if (loop)
			begin
				cnt_we = 1'b1;
				cnt_wdata = loop_addr;
			end
			else
				stop_we = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/hus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    cfg_we,
	input  wire hus_pkg::chan_t    cfg_chan,
	input  wire hus_pkg::reg_idx_t cfg_reg,
	input  wire [7:0]              cfg_wdata,
	output wire                    mem_req,
	output wire hus_pkg::word_addr_t mem_addr,
	input  wire [15:0]             mem_data,
	input  wire                    mem_strobe,
	input  wire                    dac_stb,
	output wire                    busy,
	output wire hus_pkg::dac_t     ldac,
	output wire hus_pkg::dac_t     rdac
);

	hus_pkg::chan_t rd_chan;
	logic active;
	logic loop;
	hus_pkg::byte_addr_t start_addr;
	hus_pkg::byte_addr_t end_addr;
	hus_pkg::byte_addr_t loop_addr;
	hus_pkg::vol_t lvol;
	hus_pkg::vol_t rvol;
	hus_pkg::byte_addr_t cnt;
	logic cnt_we;
	hus_pkg::byte_addr_t cnt_wdata;
	logic stop_we;
	logic mix_en;
	hus_pkg::sample_t mix_sample;
	hus_pkg::vol_t mix_lvol;
	hus_pkg::vol_t mix_rvol;

	hus_chan_regs i_hus_chan_regs (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_chan(cfg_chan), .cfg_reg(cfg_reg), .cfg_wdata(cfg_wdata),
		.rd_chan(rd_chan), .active(active), .loop(loop),
		.start_addr(start_addr), .end_addr(end_addr), .loop_addr(loop_addr),
		.lvol(lvol), .rvol(rvol), .cnt(cnt),
		.cnt_we(cnt_we), .cnt_wdata(cnt_wdata), .stop_we(stop_we)
	);

	hus i_hus (
		.clk(clk), .rst(rst), .dac_stb(dac_stb), .busy(busy),
		.rd_chan(rd_chan), .active(active), .loop(loop),
		.start_addr(start_addr), .end_addr(end_addr), .loop_addr(loop_addr),
		.lvol(lvol), .rvol(rvol), .cnt(cnt),
		.cnt_we(cnt_we), .cnt_wdata(cnt_wdata), .stop_we(stop_we),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data), .mem_strobe(mem_strobe),
		.mix_en(mix_en), .mix_sample(mix_sample), .mix_lvol(mix_lvol), .mix_rvol(mix_rvol)
	);

	hus_mixer i_hus_mixer (
		.clk(clk), .rst(rst), .dac_stb(dac_stb),
		.mix_en(mix_en), .mix_sample(mix_sample), .mix_lvol(mix_lvol), .mix_rvol(mix_rvol),
		.ldac(ldac), .rdac(rdac)
	);

endmodule

`default_nettype wire

/* tests/hus_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_chk (
	input wire                      clk,
	input wire                      rst,
	input wire                      dac_stb,
	input wire                      busy,
	input wire                      mem_req,
	input wire hus_pkg::word_addr_t mem_addr,
	input wire                      mem_strobe
);

	// a new frame only once the last one is done
	a_stb_idle: assert property (@(posedge clk) disable iff (rst) dac_stb |-> !busy)
		else $error("dac_stb arrived while busy was high");

	// request and address held until memory answers
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_strobe |=> mem_req && $stable(mem_addr))
		else $error("mem_req dropped or mem_addr moved before mem_strobe");

	a_reset_idle: assert property (@(posedge clk) rst |=> !busy && !mem_req)
		else $error("busy or mem_req high after reset");

endmodule

bind hus_top hus_chk i_hus_chk (
	.clk(clk),
	.rst(rst),
	.dac_stb(dac_stb),
	.busy(busy),
	.mem_req(mem_req),
	.mem_addr(mem_addr),
	.mem_strobe(mem_strobe)
);

`default_nettype wire

/* tests/hus_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_scoreboard (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cfg_we,
	input  wire hus_pkg::chan_t      cfg_chan,
	input  wire hus_pkg::reg_idx_t   cfg_reg,
	input  wire [7:0]                cfg_wdata,
	input  wire                      dac_stb,
	input  wire                      mem_req,
	input  wire hus_pkg::word_addr_t mem_addr,
	input  wire hus_pkg::dac_t       ldac,
	input  wire hus_pkg::dac_t       rdac,
	input  wire                      test_end,
	output int                       errors,
	output int                       checks
);

	// model copy of the register file and counters
	logic [7:0] regs [hus_pkg::HUS_CHANNELS][12];
	hus_pkg::byte_addr_t ctr [hus_pkg::HUS_CHANNELS];
	int exp_l;
	int exp_r;
	int want_l;
	int want_r;
	logic check_due;
	// word addresses the current frame should fetch, in channel order
	hus_pkg::word_addr_t addr_q [$];
	hus_pkg::word_addr_t want_a;
	logic req_q;
	int test_num;
	int test_chk;
	int test_errs;

	function automatic hus_pkg::byte_addr_t addr_field(input int c, input int r);
		return {regs[c][r + 2][5:0], regs[c][r + 1], regs[c][r]};
	endfunction

	// sums of the frame that starts now with counters stepped as it goes
	task automatic predict_frame();
		hus_pkg::byte_addr_t nxt;
		logic [15:0] word;
		int smp;
		exp_l = 0;
		exp_r = 0;
		addr_q.delete();
		for (int c = 0; c < hus_pkg::HUS_CHANNELS; c++)
		begin
			if (regs[c][hus_pkg::REG_CTRL][hus_pkg::CTRL_ACTIVE])
			begin
				addr_q.push_back(ctr[c][21:1]);
				word = hus_tb.mem[ctr[c][10:1]];
				smp = ctr[c][0] ? int'($signed(word[15:8])) : int'($signed(word[7:0]));
				exp_l += smp * int'(regs[c][hus_pkg::REG_LVOL][5:0]);
				exp_r += smp * int'(regs[c][hus_pkg::REG_RVOL][5:0]);
				nxt = ctr[c] + 22'd1;
				if (nxt != addr_field(c, hus_pkg::REG_END0))
					ctr[c] = nxt;
				else if (regs[c][hus_pkg::REG_CTRL][hus_pkg::CTRL_LOOP])
					ctr[c] = addr_field(c, hus_pkg::REG_LOOP0);
				else
					regs[c][hus_pkg::REG_CTRL][hus_pkg::CTRL_ACTIVE] = 1'b0;
			end
		end
	endtask

	task automatic compare(input string name, input hus_pkg::dac_t got, input int want);
		checks++;
		if (got !== hus_pkg::dac_t'(want))
		begin
			errors++;
			test_errs++;
			$display("ERROR %s expected 0x%05h got 0x%05h", name, hus_pkg::dac_t'(want), got);
		end
	endtask

	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int c = 0; c < hus_pkg::HUS_CHANNELS; c++)
				regs[c][hus_pkg::REG_CTRL] = 8'h00;
			exp_l = 0;
			exp_r = 0;
			check_due = 1'b0;
			addr_q.delete();
			req_q = 1'b0;
			errors = 0;
			checks = 0;
			test_num = 0;
			test_chk = 0;
			test_errs = 0;
		end
		else
		begin
			// outputs were latched on the previous edge
			if (check_due)
			begin
				compare("ldac", ldac, want_l);
				compare("rdac", rdac, want_r);
				test_chk++;
			end
			check_due = 1'b0;
			// address goes out together with the request
			if (mem_req && !req_q)
			begin
				if (addr_q.size() == 0)
				begin
					errors++;
					test_errs++;
					$display("memory request seen with no active channel left to fetch");
				end
				else
				begin
					want_a = addr_q.pop_front();
					checks++;
					if (mem_addr !== want_a)
					begin
						errors++;
						test_errs++;
						$display("ERROR mem_addr expected 0x%06h got 0x%06h", want_a, mem_addr);
					end
				end
			end
			req_q = mem_req;
			if (cfg_we && cfg_reg <= hus_pkg::REG_RVOL)
			begin
				regs[cfg_chan][cfg_reg] = cfg_wdata;
				if (cfg_reg == hus_pkg::REG_CTRL && cfg_wdata[hus_pkg::CTRL_ACTIVE])
					ctr[cfg_chan] = addr_field(int'(cfg_chan), hus_pkg::REG_START0);
			end
			if (dac_stb)
			begin
				want_l = exp_l;
				want_r = exp_r;
				check_due = 1'b1;
				predict_frame();
			end
			if (test_end)
			begin
				$display("test %0d: %0d frames checked, %0d errors", test_num, test_chk, test_errs);
				test_num++;
				test_chk = 0;
				test_errs = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/hus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hus_tb;

	localparam int CLK_NS = 40;
	localparam int TESTS = 6;

	// one register write of a test row
	typedef struct packed {
		logic [7:0] row;
		logic [2:0] chan;
		logic [3:0] idx;
		logic [7:0] val;
	} wr_t;

	logic clk;
	logic rst;
	logic cfg_we;
	hus_pkg::chan_t cfg_chan;
	hus_pkg::reg_idx_t cfg_reg;
	logic [7:0] cfg_wdata;
	logic mem_req;
	hus_pkg::word_addr_t mem_addr;
	logic [15:0] mem_data;
	logic mem_strobe;
	logic dac_stb;
	logic busy;
	hus_pkg::dac_t ldac;
	hus_pkg::dac_t rdac;
	logic test_end;
	int sb_errors;
	int sb_checks;

	logic [15:0] mem [1024];
	logic [31:0] lfsr;
	wr_t wr_tab [$];
	// frames per test for idle, single, several, one-shot, loop and rewrite
	int frames_tab [TESTS] = '{3, 6, 5, 6, 10, 6};
	int limit_ns = 0;
	int lat;

	hus_top i_hus_top (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_chan(cfg_chan), .cfg_reg(cfg_reg), .cfg_wdata(cfg_wdata),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data), .mem_strobe(mem_strobe),
		.dac_stb(dac_stb), .busy(busy), .ldac(ldac), .rdac(rdac)
	);

	hus_scoreboard i_hus_scoreboard (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_chan(cfg_chan), .cfg_reg(cfg_reg), .cfg_wdata(cfg_wdata),
		.dac_stb(dac_stb), .mem_req(mem_req), .mem_addr(mem_addr), .ldac(ldac), .rdac(rdac),
		.test_end(test_end), .errors(sb_errors), .checks(sb_checks)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	task automatic add_write(input int row, input int ch, input int r, input logic [7:0] v);
		wr_t w;
		w.row = 8'(row);
		w.chan = 3'(ch);
		w.idx = 4'(r);
		w.val = v;
		wr_tab.push_back(w);
	endtask

	// address and volume bytes first, control last
	task automatic add_chan(input int row, input int ch, input int sa, input int ea,
		input int la, input int lv, input int rv, input logic [7:0] ctrl);
		for (int b = 0; b < 3; b++)
		begin
			add_write(row, ch, int'(hus_pkg::REG_START0) + b, 8'(sa >> (8 * b)));
			add_write(row, ch, int'(hus_pkg::REG_END0) + b, 8'(ea >> (8 * b)));
			add_write(row, ch, int'(hus_pkg::REG_LOOP0) + b, 8'(la >> (8 * b)));
		end
		add_write(row, ch, int'(hus_pkg::REG_LVOL), 8'(lv));
		add_write(row, ch, int'(hus_pkg::REG_RVOL), 8'(rv));
		add_write(row, ch, int'(hus_pkg::REG_CTRL), ctrl);
	endtask

	task automatic write_reg(input wr_t w);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_chan <= w.chan;
		cfg_reg <= w.idx;
		cfg_wdata <= w.val;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic strobe_frame();
		@(posedge clk);
		dac_stb <= 1'b1;
		@(posedge clk);
		dac_stb <= 1'b0;
		@(posedge clk);
		while (busy)
			@(posedge clk);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// sample memory answering after 1 to 8 cycles
	always
	begin
		@(posedge clk);
		if (mem_req && !rst)
		begin
			lat = 1 + int'(rand_bits(3));
			repeat (lat - 1)
				@(posedge clk);
			mem_strobe <= 1'b1;
			mem_data <= mem[mem_addr[9:0]];
			@(posedge clk);
			mem_strobe <= 1'b0;
		end
	end

	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int total;
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_chan = '0;
		cfg_reg = '0;
		cfg_wdata = 8'h00;
		mem_data = 16'h0000;
		mem_strobe = 1'b0;
		dac_stb = 1'b0;
		test_end = 1'b0;
		lfsr = 32'hfb81d433;
		for (int a = 0; a < 1024; a++)
			mem[a] = rand_bits(16) ^ 16'(a);
		add_chan(1, 0, 'h010, 'h020, 'h000, 20, 5, 8'h80);
		add_chan(2, 1, 'h040, 'h080, 'h000, 63, 0, 8'h80);
		add_chan(2, 3, 'h101, 'h180, 'h000, 7, 63, 8'h80);
		add_chan(2, 7, 'h200, 'h240, 'h000, 33, 12, 8'h80);
		add_chan(3, 2, 'h300, 'h303, 'h000, 40, 40, 8'h80);
		add_chan(4, 4, 'h400, 'h405, 'h402, 50, 9, 8'hc0);
		add_write(5, 1, int'(hus_pkg::REG_CTRL), 8'h00);
		add_write(5, 4, int'(hus_pkg::REG_CTRL), 8'h00);
		add_write(5, 2, int'(hus_pkg::REG_CTRL), 8'h80);
		add_write(5, 3, int'(hus_pkg::REG_CTRL), 8'h80);
		// one extra strobe publishes the last frame
		total = 1;
		for (int t = 0; t < TESTS; t++)
			total += frames_tab[t];
		limit_ns = (total * (hus_pkg::HUS_CHANNELS * 16 + 8) + wr_tab.size() * 2 + 200) * CLK_NS;
		repeat (5)
			@(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < TESTS; t++)
		begin
			foreach (wr_tab[w])
				if (int'(wr_tab[w].row) == t)
					write_reg(wr_tab[w]);
			for (int f = 0; f < frames_tab[t]; f++)
				strobe_frame();
			@(posedge clk);
			test_end <= 1'b1;
			@(posedge clk);
			test_end <= 1'b0;
		end
		strobe_frame();
		@(posedge clk);
		$display("%0d tests, %0d checks, %0d errors", TESTS, sb_checks, sb_errors);
		if (sb_errors == 0 && sb_checks > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hus_top.f */
design/hus_pkg.sv
design/hus_chan_regs.sv
design/hus_mixer.sv
design/hus.sv
design/hus_top.sv
tests/hus_chk.sv
tests/hus_scoreboard.sv
tests/hus_tb.sv

/* run.sh */
#!/bin/bash
# build and run the hus_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module hus_tb -f hus_top.f -o sim_hus \
	&& ./obj_dir/sim_hus > sim.log 2>&1 \
	|| echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
